//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert -Wno-fatal --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing -Wall --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/mtx_macros.svh
`ifndef MTX_MACROS_SVH
`define MTX_MACROS_SVH

// element width in bits, a multiple of 8 so that whole bytes carry it
`define MTX_WIDTH 16

// matrix order, the matrix is MTX_N by MTX_N
`define MTX_N 8

// AXI4-Lite address and data widths
`define AXI_ADDR_W 12
`define AXI_DATA_W 32

`endif

//--- common/mtx_pkg.sv
`include "mtx_macros.svh"

package mtx_pkg;

  // one matrix element
  typedef logic [`MTX_WIDTH-1:0] elem_t;

  // a full row, element 0 sits in the lowest bits
  typedef elem_t [`MTX_N-1:0] row_t;

  // row or column position inside the matrix
  typedef logic [$clog2(`MTX_N)-1:0] idx_t;

  // register map of the AXI4-Lite slave
  typedef enum logic [`AXI_ADDR_W-1:0] {
    REG_CTRL   = 'h000, // bit0 start, bit1 clear error
    REG_STATUS = 'h004, // bit0 busy, bit1 result available, bit2 start error, 7:4 rows
    REG_RESULT = 'h008, // pops one element of the transposed matrix
    REG_MATRIX = 'h100  // word r*N+c holds element (r, c)
  } reg_addr_e;

endpackage

//--- hdl/axil_regs.sv
`include "mtx_macros.svh"

module axil_regs (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic [`AXI_ADDR_W-1:0]  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`AXI_DATA_W-1:0]  wdata,
  input  logic [`AXI_DATA_W/8-1:0] wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`AXI_ADDR_W-1:0]  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [`AXI_DATA_W-1:0]  rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    mat_we,
  output mtx_pkg::idx_t           mat_wrow,
  output mtx_pkg::idx_t           mat_wcol,
  output mtx_pkg::elem_t          mat_wdata,
  output logic                    start,
  input  logic                    loading,
  input  logic                    xpose_busy,
  output logic                    pop,
  input  mtx_pkg::row_t           fifo_row,
  input  logic [3:0]              fifo_count,
  input  logic                    fifo_empty
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int         MAT_WORDS   = `MTX_N * `MTX_N;

  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_ctrl;
  logic                   wr_mat;
  logic                   start_req;
  logic                   start_ok;
  logic                   busy_all;
  logic                   start_err;
  logic [`AXI_ADDR_W-1:0] mat_word;
  logic [`AXI_DATA_W-1:0] status;
  mtx_pkg::idx_t          col_cnt;

  // write address decode, AW and W are taken together
  assign wr_fire  = awready && awvalid && wready && wvalid;
  assign mat_word = (awaddr - mtx_pkg::REG_MATRIX) >> 2;
  assign wr_ctrl  = (awaddr == mtx_pkg::REG_CTRL);
  assign wr_mat   = (awaddr >= mtx_pkg::REG_MATRIX) && (mat_word < MAT_WORDS) &&
                    (awaddr[1:0] == 2'b00);

  // an element write needs all of its byte lanes
  assign mat_we    = wr_fire && wr_mat && (&wstrb[`MTX_WIDTH/8-1:0]);
  assign mat_wrow  = mtx_pkg::idx_t'(mat_word / `MTX_N);
  assign mat_wcol  = mtx_pkg::idx_t'(mat_word % `MTX_N);
  assign mat_wdata = wdata[`MTX_WIDTH-1:0];

  // start counts as busy until the loader has picked it up
  assign busy_all  = loading | xpose_busy | start;
  assign start_req = wr_fire && wr_ctrl && wstrb[0] && wdata[0];
  assign start_ok  = !busy_all && fifo_empty; // no job over unread results
  assign status    = `AXI_DATA_W'({fifo_count, 1'b0, start_err, !fifo_empty, busy_all});

  always_ff @(posedge clk) begin
    if (!resetn) begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= RESP_OKAY;
      start     <= 1'b0;
      start_err <= 1'b0;
    end else begin
      start <= start_req && start_ok; // single cycle pulse

      if (bvalid && bready)
        bvalid <= 1'b0;

      if (wr_fire) begin
        awready <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b1;
        bresp   <= (wr_ctrl || wr_mat) ? RESP_OKAY : RESP_SLVERR;
      end else if (awvalid && wvalid && !awready && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end

      // a rejected start in the same write wins over the clear
      if (wr_fire && wr_ctrl && wstrb[0] && wdata[1])
        start_err <= 1'b0;
      if (start_req && !start_ok)
        start_err <= 1'b1;
    end
  end

  assign rd_fire = arready && arvalid;

  // the head row leaves the FIFO with its last element
  assign pop = rd_fire && (araddr == mtx_pkg::REG_RESULT) && !fifo_empty &&
               (col_cnt == mtx_pkg::idx_t'(`MTX_N - 1));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rresp   <= RESP_OKAY;
      col_cnt <= '0;
    end else begin
      if (rvalid && rready)
        rvalid <= 1'b0;

      if (rd_fire) begin
        arready <= 1'b0;
        rvalid  <= 1'b1;
        rresp   <= RESP_OKAY;
        case (araddr)
          mtx_pkg::REG_CTRL,
          mtx_pkg::REG_STATUS: ;
          mtx_pkg::REG_RESULT: begin
            if (fifo_empty)
              rresp <= RESP_SLVERR;
            else if (col_cnt == mtx_pkg::idx_t'(`MTX_N - 1))
              col_cnt <= '0;
            else
              col_cnt <= col_cnt + 1'b1;
          end
          default: rresp <= RESP_SLVERR;
        endcase
      end else if (arvalid && !arready && !rvalid) begin
        arready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (araddr)
        mtx_pkg::REG_STATUS: rdata <= status;
        mtx_pkg::REG_RESULT: begin
          if (fifo_empty)
            rdata <= '0;
          else
            rdata <= `AXI_DATA_W'(fifo_row[col_cnt]);
        end
        default: rdata <= '0; // CTRL reads back as zero
      endcase
    end
  end

endmodule

//--- hdl/mtx_loader.sv
`include "mtx_macros.svh"

module mtx_loader (
  input  logic           clk,
  input  logic           resetn,
  input  logic           mat_we,
  input  mtx_pkg::idx_t  mat_wrow,
  input  mtx_pkg::idx_t  mat_wcol,
  input  mtx_pkg::elem_t mat_wdata,
  input  logic           start,
  output logic           row_en,
  output mtx_pkg::row_t  row_data,
  output logic           loading
);

  // input matrix, one packed row per entry
  mtx_pkg::row_t rows [`MTX_N];
  mtx_pkg::idx_t row_cnt;

  // host writes land at any time, a write during a job counts for the next one
  always_ff @(posedge clk) begin
    if (mat_we)
      rows[mat_wrow][mat_wcol] <= mat_wdata;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      loading <= 1'b0;
      row_cnt <= '0;
    end else if (start && !loading) begin
      loading <= 1'b1;
      row_cnt <= '0;
    end else if (loading) begin
      if (row_cnt == mtx_pkg::idx_t'(`MTX_N - 1)) begin
        loading <= 1'b0; // last row goes out in this cycle
        row_cnt <= '0;
      end else begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // one row per cycle, back to back, while the job runs
  assign row_en   = loading;
  assign row_data = rows[row_cnt];

endmodule

//--- hdl/mtx_top.sv
`include "mtx_macros.svh"

module mtx_top (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [`AXI_ADDR_W-1:0]   awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [`AXI_DATA_W-1:0]   wdata,
  input  logic [`AXI_DATA_W/8-1:0] wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [`AXI_ADDR_W-1:0]   araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [`AXI_DATA_W-1:0]   rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready
);

  logic           mat_we;
  mtx_pkg::idx_t  mat_wrow;
  mtx_pkg::idx_t  mat_wcol;
  mtx_pkg::elem_t mat_wdata;
  logic           start;
  logic           loading;
  logic           row_en;
  mtx_pkg::row_t  row_data;
  logic           xpose_busy;
  logic           out_valid;
  mtx_pkg::row_t  out_row;
  logic           pop;
  mtx_pkg::row_t  fifo_row;
  logic [3:0]     fifo_count;
  logic           fifo_empty;

  axil_regs u_regs (
    .clk        (clk),
    .resetn     (resetn),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .mat_we     (mat_we),
    .mat_wrow   (mat_wrow),
    .mat_wcol   (mat_wcol),
    .mat_wdata  (mat_wdata),
    .start      (start),
    .loading    (loading),
    .xpose_busy (xpose_busy),
    .pop        (pop),
    .fifo_row   (fifo_row),
    .fifo_count (fifo_count),
    .fifo_empty (fifo_empty)
  );

  mtx_loader u_loader (
    .clk       (clk),
    .resetn    (resetn),
    .mat_we    (mat_we),
    .mat_wrow  (mat_wrow),
    .mat_wcol  (mat_wcol),
    .mat_wdata (mat_wdata),
    .start     (start),
    .row_en    (row_en),
    .row_data  (row_data),
    .loading   (loading)
  );

  transpose u_transpose (
    .clk       (clk),
    .resetn    (resetn),
    .row_en    (row_en),
    .row_data  (row_data),
    .out_row   (out_row),
    .out_valid (out_valid),
    .busy      (xpose_busy)
  );

  // transposed rows wait here until the host has read them
  row_fifo u_fifo (
    .clk      (clk),
    .resetn   (resetn),
    .push     (out_valid),
    .push_row (out_row),
    .pop      (pop),
    .pop_row  (fifo_row),
    .empty    (fifo_empty),
    .count    (fifo_count)
  );

endmodule

//--- src.f
+incdir+common
common/mtx_pkg.sv
transpose/transpose.sv
transpose/row_fifo.sv
hdl/mtx_loader.sv
hdl/axil_regs.sv
hdl/mtx_top.sv
verif/clk_gen.sv
verif/tb_top.sv

//--- transpose/row_fifo.sv
`include "mtx_macros.svh"

module row_fifo (
  input  logic          clk,
  input  logic          resetn,
  input  logic          push,
  input  mtx_pkg::row_t push_row,
  input  logic          pop,
  output mtx_pkg::row_t pop_row,
  output logic          empty,
  output logic [3:0]    count
);

  mtx_pkg::row_t mem [`MTX_N];
  mtx_pkg::idx_t wr_ptr;
  mtx_pkg::idx_t rd_ptr;
  logic          full;
  logic          do_push;
  logic          do_pop;

  function automatic mtx_pkg::idx_t next_ptr(input mtx_pkg::idx_t ptr);
    if (ptr == mtx_pkg::idx_t'(`MTX_N - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign empty   = (count == 4'd0);
  assign full    = (count == 4'(`MTX_N));
  assign do_push = push && !full; // a push into a full FIFO is lost
  assign do_pop  = pop && !empty;
  assign pop_row = mem[rd_ptr];   // head row is visible without latency

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 4'd0;
    end else begin
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      count <= count + 4'(do_push) - 4'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_row;
  end

endmodule

//--- transpose/transpose.sv
`include "mtx_macros.svh"

module transpose (
  input  logic          clk,
  input  logic          resetn,
  input  logic          row_en,
  input  mtx_pkg::row_t row_data,
  output mtx_pkg::row_t out_row,
  output logic          out_valid,
  output logic          busy
);

  // cols[j] collects column j of the input, element i of it is input (i, j)
  mtx_pkg::row_t cols [`MTX_N];
  mtx_pkg::idx_t ld_cnt;
  mtx_pkg::idx_t dr_cnt;
  logic          draining;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ld_cnt    <= '0;
      dr_cnt    <= '0;
      draining  <= 1'b0;
      out_valid <= 1'b0;
      busy      <= 1'b0;
    end else begin
      out_valid <= draining; // one output row per draining cycle
      busy      <= row_en | (ld_cnt != '0) | draining;

      if (row_en && !draining) begin
        if (ld_cnt == mtx_pkg::idx_t'(`MTX_N - 1)) begin
          // last row is in, the columns are complete after this edge
          ld_cnt   <= '0;
          draining <= 1'b1;
          dr_cnt   <= '0;
        end else begin
          ld_cnt <= ld_cnt + 1'b1;
        end
      end

      if (draining) begin
        if (dr_cnt == mtx_pkg::idx_t'(`MTX_N - 1)) begin
          draining <= 1'b0;
          dr_cnt   <= '0;
        end else begin
          dr_cnt <= dr_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (draining) begin
      // column 0 leaves first, the rest move down one place
      out_row <= cols[0];
      for (int j = 0; j < `MTX_N - 1; j++) begin
        cols[j] <= cols[j+1];
      end
      cols[`MTX_N-1] <= '0;
    end else if (row_en) begin
      for (int j = 0; j < `MTX_N; j++) begin
        cols[j][ld_cnt] <= row_data[j]; // element j of the row goes to column j
      end
    end
  end

endmodule

//--- verif/clk_gen.sv
module clk_gen (
  output logic clk,
  output logic resetn
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD  = 50; // 100 ns clock
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    resetn = 1'b1; // released on a falling edge like the rest of the stimulus
  end

endmodule

//--- verif/tb_top.sv
`include "mtx_macros.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N               = `MTX_N;
  localparam int JOB_BUDGET      = 2500; // one job with 128 AXI transfers and stalls
  localparam int JOBS            = 8;
  localparam int WATCHDOG_CYCLES = JOBS * JOB_BUDGET;
  localparam int HS_LIMIT        = 50;
  localparam int POLL_LIMIT      = 100;
  localparam logic [1:0] OKAY    = 2'b00;
  localparam logic [1:0] SLVERR  = 2'b10;

  logic                     clk;
  logic                     resetn;
  logic [`AXI_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [`AXI_DATA_W-1:0]   wdata;
  logic [`AXI_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [`AXI_ADDR_W-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [`AXI_DATA_W-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;

  // what the host believes is in the input matrix
  logic [`MTX_WIDTH-1:0] model [N][N];
  int value_errors = 0;
  int other_errors = 0;

  clk_gen u_clk (.clk(clk), .resetn(resetn));

  mtx_top dut (
    .clk(clk), .resetn(resetn),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    other_errors++;
    $display("[ERROR] %s", msg);
  endtask

  // outputs are sampled on the falling edge, where they are stable
  task automatic axil_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                            input int stall, output logic [1:0] resp);
    int waited;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = '1;
    wvalid  = 1'b1;
    waited  = 0;
    while (!(awready && wready) && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (waited < HS_LIMIT) else report_failure("write address/data never accepted");
    @(negedge clk); // the transfer happened on the rising edge before
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waited  = 0;
    while (!bvalid && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (bvalid) else report_failure("no write response arrived");
    repeat (stall) begin
      @(negedge clk);
      assert (bvalid) else report_failure("bvalid dropped while bready was low");
    end
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [`AXI_ADDR_W-1:0] addr, input int stall,
                           output logic [31:0] data, output logic [1:0] resp);
    int          waited;
    logic [31:0] held;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    waited  = 0;
    while (!arready && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (waited < HS_LIMIT) else report_failure("read address never accepted");
    @(negedge clk);
    arvalid = 1'b0;
    waited  = 0;
    while (!rvalid && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (rvalid) else report_failure("no read data arrived");
    held = rdata;
    repeat (stall) begin
      @(negedge clk);
      assert (rvalid && rdata === held) else report_failure("read channel changed during a stall");
    end
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // STATUS as the register map lays it out
  function automatic logic [31:0] status_word(input logic busy, input logic avail,
                                               input logic err, input logic [3:0] rows);
    return {24'h0, rows, 1'b0, err, avail, busy};
  endfunction

  task automatic expect_status(input string name, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(mtx_pkg::REG_STATUS, 0, data, resp);
    check_value(name, exp, data);
    check_value({name, " rresp"}, OKAY, resp);
  endtask

  task automatic write_element(input string name, input int r, input int c, input int stall);
    logic [1:0]             resp;
    logic [`AXI_ADDR_W-1:0] addr;
    addr = `AXI_ADDR_W'(int'(mtx_pkg::REG_MATRIX) + 4 * (r * N + c));
    axil_write(addr, 32'(model[r][c]), stall, resp);
    check_value({name, " matrix write bresp"}, OKAY, resp);
  endtask

  task automatic write_matrix(input string name, input int stall_max);
    for (int r = 0; r < N; r++)
      for (int c = 0; c < N; c++)
        write_element(name, r, c, $urandom_range(stall_max));
  endtask

  task automatic random_fill();
    for (int r = 0; r < N; r++)
      for (int c = 0; c < N; c++)
        model[r][c] = `MTX_WIDTH'($urandom);
  endtask

  task automatic write_ctrl(input string name, input logic [31:0] value);
    logic [1:0] resp;
    axil_write(mtx_pkg::REG_CTRL, value, 0, resp);
    check_value({name, " ctrl bresp"}, OKAY, resp);
  endtask

  task automatic wait_for_result();
    logic [31:0] status;
    logic [1:0]  resp;
    int          polls;
    status = '0;
    polls  = 0;
    while (status[7:4] != 4'(N) && polls < POLL_LIMIT) begin
      axil_read(mtx_pkg::REG_STATUS, 0, status, resp);
      polls++;
    end
    assert (status[7:4] == 4'(N)) else report_failure("STATUS never reported a full result");
  endtask

  // result element (r, c) is input element (c, r)
  task automatic check_result(input string name, input int stall_max);
    logic [31:0] data;
    logic [1:0]  resp;
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        axil_read(mtx_pkg::REG_RESULT, $urandom_range(stall_max), data, resp);
        check_value(name, 32'(model[c][r]), data);
        check_value({name, " rresp"}, OKAY, resp);
      end
    end
  endtask

  task automatic test_reset_status();
    logic [31:0] data;
    logic [1:0]  resp;
    expect_status("test_reset_status status", 32'h0);
    axil_read(mtx_pkg::REG_RESULT, 0, data, resp);
    check_value("test_reset_status result data", 32'h0, data);
    check_value("test_reset_status result rresp", SLVERR, resp);
  endtask

  task automatic test_identity_pattern();
    for (int r = 0; r < N; r++)
      for (int c = 0; c < N; c++)
        model[r][c] = `MTX_WIDTH'(r * 16 + c);
    write_matrix("test_identity_pattern", 0);
    write_ctrl("test_identity_pattern", 32'h1);
    wait_for_result();
    check_result("test_identity_pattern", 0);
    expect_status("test_identity_pattern drained", status_word(0, 0, 0, 0));
  endtask

  task automatic test_random_matrix();
    repeat (3) begin
      random_fill();
      write_matrix("test_random_matrix", 0);
      write_ctrl("test_random_matrix", 32'h1);
      wait_for_result();
      check_result("test_random_matrix", 0);
    end
  endtask

  task automatic test_start_rejected();
    random_fill();
    write_matrix("test_start_rejected", 0);
    write_ctrl("test_start_rejected", 32'h1);
    write_ctrl("test_start_rejected busy", 32'h1); // the first job is still running
    wait_for_result();
    expect_status("test_start_rejected busy error", status_word(0, 1, 1, 4'(N)));
    write_ctrl("test_start_rejected clear", 32'h2);
    expect_status("test_start_rejected cleared", status_word(0, 1, 0, 4'(N)));
    write_ctrl("test_start_rejected unread", 32'h1);
    expect_status("test_start_rejected unread error", status_word(0, 1, 1, 4'(N)));
    write_ctrl("test_start_rejected clear", 32'h2);
    check_result("test_start_rejected", 0);
    expect_status("test_start_rejected drained", status_word(0, 0, 0, 0));
  endtask

  task automatic test_partial_rewrite();
    int r;
    int c;
    repeat (5) begin
      r = $urandom_range(N - 1);
      c = $urandom_range(N - 1);
      model[r][c] = `MTX_WIDTH'($urandom);
      write_element("test_partial_rewrite", r, c, 0);
    end
    write_ctrl("test_partial_rewrite", 32'h1);
    wait_for_result();
    check_result("test_partial_rewrite", 0);
  endtask

  task automatic test_axi_stalls();
    random_fill();
    write_matrix("test_axi_stalls", 5);
    write_ctrl("test_axi_stalls", 32'h1);
    wait_for_result();
    check_result("test_axi_stalls", 5);
    expect_status("test_axi_stalls drained", status_word(0, 0, 0, 0));
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h48c7df70));
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    wait (resetn === 1'b1);
    test_reset_status();
    test_identity_pattern();
    test_random_matrix();
    test_start_rejected();
    test_partial_rewrite();
    test_axi_stalls();
    $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
